// ==== hw/fetch_pkg.sv ====
////////////////////
// fetch stage package
// address and word types, fixed entry points, selector encodings
// and the item format passed from the prefetch queue to IF-ID
////////////////////

package fetch_pkg;

  // byte address and raw instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  // index into the vectored interrupt table
  typedef logic [4:0]  vec_idx_t;

  // boot entry sits at this offset above the aligned boot base
  localparam logic [7:0]  BootOffset      = 8'h80;
  // low bits dropped from mtvec and boot base
  localparam int unsigned MtvecAlignBits  = 8;
  // debug module entry points
  localparam addr_t       DmHaltAddr      = 32'h1A11_0800;
  localparam addr_t       DmExceptionAddr = 32'h1A11_0808;
  // every internal interrupt shares the nmi slot
  localparam vec_idx_t    NmiVector       = 5'd31;
  // prefetch queue entries, power of two
  localparam int unsigned FifoDepth       = 2;

  // next pc source
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // handler address source
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  typedef struct packed {
    logic     irq_int;
    vec_idx_t lower_cause;
  } exc_cause_t;

  // one fetched word with its address and bus error
  typedef struct packed {
    addr_t  addr;
    instr_t rdata;
    logic   err;
  } fetch_item_t;

endpackage

// ==== hw/fetch_target_sel.sv ====
////////////////////
// fetch target select
// forms the exception handler address and picks the next fetch address
////////////////////

`timescale 1ns/10ps

module fetch_target_sel (
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::exc_cause_t  exc_cause_i,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::addr_t       branch_target_ex_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  fetch_pkg::addr_t       csr_mtvec_i,
  output fetch_pkg::addr_t       branch_addr_o
);
  import fetch_pkg::*;

  addr_t    mtvec_base;
  addr_t    boot_base;
  addr_t    exc_pc;
  vec_idx_t irq_vec;

  // low bits of mtvec and boot address are ignored
  assign mtvec_base = {csr_mtvec_i[31:MtvecAlignBits], {MtvecAlignBits{1'b0}}};
  assign boot_base  = {boot_addr_i[31:MtvecAlignBits], {MtvecAlignBits{1'b0}}};

  // internal interrupts all land on the nmi slot
  assign irq_vec = exc_cause_i.irq_int ? NmiVector : exc_cause_i.lower_cause;

  ////////////////////
  // handler address
  ////////////////////
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      // one word per vector slot
      EXC_PC_IRQ:     exc_pc = mtvec_base + (addr_t'(irq_vec) << 2);
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = mtvec_base;
    endcase
  end

  ////////////////////
  // next fetch address
  ////////////////////
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: branch_addr_o = boot_base + addr_t'(BootOffset);
      PC_JUMP: branch_addr_o = branch_target_ex_i;
      // trap entry
      PC_EXC:  branch_addr_o = exc_pc;
      // return from trap and from debug
      PC_ERET: branch_addr_o = csr_mepc_i;
      PC_DRET: branch_addr_o = csr_depc_i;
      default: branch_addr_o = boot_base + addr_t'(BootOffset);
    endcase
  end

endmodule

// ==== hw/fetch_buffer.sv ====
////////////////////
// prefetch buffer
// issues in-order word fetches on the req/gnt/rvalid bus and
// queues the returned words for the IF-ID register
////////////////////

`timescale 1ns/10ps

module fetch_buffer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   branch_i,
  input  fetch_pkg::addr_t       branch_addr_i,
  input  logic                   fetch_ready_i,
  output logic                   fetch_valid_o,
  output fetch_pkg::fetch_item_t fetch_item_o,
  output logic                   busy_o,
  // instruction bus
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_t      instr_rdata_i,
  input  logic                   instr_bus_err_i
);
  import fetch_pkg::*;

  // bus side control
  logic  req_q, req_d;
  logic  out_q, out_d;
  logic  stale_q, stale_d;
  logic  inflight_next;
  logic  launch;
  // next word to request and the word currently on the bus
  addr_t next_addr_q, next_addr_d;
  addr_t addr_n;
  addr_t req_addr_q;

  // queue storage and pointers
  fetch_item_t                  queue_q [FifoDepth];
  fetch_item_t                  new_item;
  logic [$clog2(FifoDepth)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(FifoDepth):0]   count_q, count_d;
  logic                         push, pop;

  ////////////////////
  // bus request
  ////////////////////

  // something still on the bus next cycle, either waiting for gnt or for rvalid
  assign inflight_next = req_q | (out_q & ~instr_rvalid_i);

  // a new request only starts on an idle bus with a free queue slot
  assign launch = req_i & ~inflight_next & (count_d < FifoDepth);

  // a branch retargets the next request, words are always aligned
  assign addr_n      = branch_i ? {branch_addr_i[31:2], 2'b00} : next_addr_q;
  assign next_addr_d = launch ? addr_n + 32'd4 : addr_n;

  // hold req until granted, then wait for the single response
  assign req_d = (req_q & ~instr_gnt_i) | launch;
  assign out_d = (req_q & instr_gnt_i) | (out_q & ~instr_rvalid_i);

  // old-path request stays marked until its response has come back
  assign stale_d = inflight_next & (branch_i | stale_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      out_q       <= 1'b0;
      stale_q     <= 1'b0;
      next_addr_q <= '0;
      req_addr_q  <= '0;
    end else begin
      req_q       <= req_d;
      out_q       <= out_d;
      stale_q     <= stale_d;
      next_addr_q <= next_addr_d;
      if (launch) begin
        req_addr_q <= addr_n;
      end
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = req_addr_q;
  assign busy_o       = req_q | out_q;

  ////////////////////
  // instruction queue
  ////////////////////

  // drop stale responses and anything arriving with a branch
  assign push = out_q & instr_rvalid_i & ~stale_q & ~branch_i;
  assign pop  = fetch_valid_o & fetch_ready_i;

  // req_addr_q is unchanged while the response is pending
  assign new_item = '{addr: req_addr_q, rdata: instr_rdata_i, err: instr_bus_err_i};

  always_comb begin
    count_d = count_q;
    if (branch_i) begin
      count_d = '0;
    end else if (push && !pop) begin
      count_d = count_q + 1'b1;
    end else if (pop && !push) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      count_q <= count_d;
      if (branch_i) begin
        // flush
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= new_item;
    end
  end

  assign fetch_valid_o = (count_q != '0);
  assign fetch_item_o  = queue_q[rd_ptr_q];

  ////////////////////
  // assertions
  ////////////////////

  // requested address is known and word aligned
  a_req_addr_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> !$isunknown(instr_addr_o) && (instr_addr_o[1:0] == 2'b00));

  // slot reservation at launch keeps every response inside the queue
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> (count_q < FifoDepth));

endmodule

// ==== hw/fetch_id_reg.sv ====
////////////////////
// IF-ID register
// merges bus and pmp errors and holds the instruction for decode
////////////////////

`timescale 1ns/10ps

module fetch_id_reg (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fetch_valid_i,
  input  fetch_pkg::fetch_item_t fetch_item_i,
  input  logic                   id_in_ready_i,
  input  logic                   pc_set_i,
  input  logic                   instr_valid_clear_i,
  input  logic                   pmp_err_if_i,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output fetch_pkg::instr_t      instr_rdata_id_o,
  output fetch_pkg::addr_t       pc_id_o,
  output logic                   instr_fetch_err_o
);
  import fetch_pkg::*;

  logic transfer;
  logic load;
  logic if_err;
  logic valid_q, valid_d;
  logic new_q;

  // handshake with the prefetch queue
  assign transfer = fetch_valid_i & id_in_ready_i;
  // a pc set in the same cycle squashes the word
  assign load     = transfer & ~pc_set_i;

  // pmp check is done on the address currently in IF
  assign if_err = fetch_item_i.err | pmp_err_if_i;

  // valid stays until decode clears it
  assign valid_d = load | (valid_q & ~instr_valid_clear_i);

  ////////////////////
  // control flops
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // one cycle pulse after each accepted word
      new_q   <= load;
    end
  end

  ////////////////////
  // payload
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (load) begin
      instr_rdata_id_o  <= fetch_item_i.rdata;
      pc_id_o           <= fetch_item_i.addr;
      instr_fetch_err_o <= if_err;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  // a fresh instruction in ID carries a known address, word and error
  a_new_is_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> !$isunknown({pc_id_o, instr_rdata_id_o, instr_fetch_err_o}));

endmodule

// ==== hw/fetch_stage.sv ====
////////////////////
// instruction fetch stage
// next pc select, prefetch buffer and IF-ID register
////////////////////

`timescale 1ns/10ps

module fetch_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // control
  input  logic                   req_i,
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::exc_cause_t  exc_cause_i,
  input  fetch_pkg::addr_t       branch_target_ex_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  fetch_pkg::addr_t       csr_mtvec_i,
  input  fetch_pkg::addr_t       boot_addr_i,
  output logic                   csr_mtvec_init_o,
  // decode side
  input  logic                   id_in_ready_i,
  input  logic                   instr_valid_clear_i,
  input  logic                   pmp_err_if_i,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output fetch_pkg::instr_t      instr_rdata_id_o,
  output fetch_pkg::addr_t       pc_id_o,
  output logic                   instr_fetch_err_o,
  output fetch_pkg::addr_t       pc_if_o,
  output logic                   if_busy_o,
  // instruction bus
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_t      instr_rdata_i,
  input  logic                   instr_bus_err_i
);
  import fetch_pkg::*;

  addr_t       branch_addr;
  fetch_item_t fetch_item;
  logic        fetch_valid;
  logic        fetch_ready;

  // decode ready is the only stall source
  assign fetch_ready = id_in_ready_i;

  // csr file loads mtvec on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  fetch_target_sel i_target_sel (
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .exc_cause_i        (exc_cause_i),
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .branch_addr_o      (branch_addr)
  );

  fetch_buffer i_fetch_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (branch_addr),
    .fetch_ready_i   (fetch_ready),
    .fetch_valid_o   (fetch_valid),
    .fetch_item_o    (fetch_item),
    .busy_o          (if_busy_o),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i)
  );

  // address of the word waiting at the head of the queue
  assign pc_if_o = fetch_item.addr;

  fetch_id_reg i_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_item_i        (fetch_item),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .pmp_err_if_i        (pmp_err_if_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .pc_id_o             (pc_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o)
  );

endmodule

// ==== verification/fetch_mem_model.sv ====
////////////////////
// instruction memory model
// serves the fetch bus with random grant and response delays
////////////////////

`timescale 1ns/10ps

module fetch_mem_model (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_req_i,
  input  fetch_pkg::addr_t  instr_addr_i,
  output logic              instr_gnt_o,
  output logic              instr_rvalid_o,
  output fetch_pkg::instr_t instr_rdata_o,
  output logic              instr_bus_err_o
);
  import fetch_pkg::*;

  // memory content is the address scrambled with a fixed mask
  localparam instr_t DataMask = 32'hA5A5_0000;

  int    gnt_wait;
  int    rsp_wait;
  logic  gnt_armed;
  logic  pending;
  addr_t rsp_addr;

  initial begin
    instr_gnt_o     = 1'b0;
    instr_rvalid_o  = 1'b0;
    instr_rdata_o   = '0;
    instr_bus_err_o = 1'b0;
    gnt_wait        = 0;
    rsp_wait        = 0;
    gnt_armed       = 1'b0;
    pending         = 1'b0;
    rsp_addr        = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (!rst_ni) begin
        instr_gnt_o    = 1'b0;
        instr_rvalid_o = 1'b0;
        gnt_armed      = 1'b0;
        pending        = 1'b0;
      end else begin
        // a grant driven last cycle was taken at this edge
        if (instr_gnt_o) begin
          pending  = 1'b1;
          rsp_wait = $urandom_range(3, 1);
        end
        instr_gnt_o    = 1'b0;
        instr_rvalid_o = 1'b0;
        if (pending) begin
          // response 1 to 3 cycles after the grant
          rsp_wait = rsp_wait - 1;
          if (rsp_wait == 0) begin
            instr_rvalid_o  = 1'b1;
            instr_rdata_o   = rsp_addr ^ DataMask;
            // upper half of every 8k block faults
            instr_bus_err_o = rsp_addr[12];
            pending         = 1'b0;
          end
        end else if (instr_req_i) begin
          // grant delay picked once per request
          if (!gnt_armed) begin
            gnt_wait  = $urandom_range(3, 0);
            gnt_armed = 1'b1;
          end
          if (gnt_wait == 0) begin
            instr_gnt_o = 1'b1;
            rsp_addr    = instr_addr_i;
            gnt_armed   = 1'b0;
          end else begin
            gnt_wait = gnt_wait - 1;
          end
        end
      end
    end
  end

endmodule

// ==== verification/fetch_stage_tb.sv ====
////////////////////
// fetch stage testbench
// random bus timing and decode stalls, reference pc tracking,
// bus and IF-ID protocol checks
////////////////////

`timescale 1ns/10ps

module fetch_stage_tb;
  import fetch_pkg::*;

  localparam int unsigned Seed        = 32'he098_5e70;
  localparam instr_t      DataMask    = 32'hA5A5_0000;
  localparam int          NewTimeout  = 300;
  localparam int          BusTimeout  = 60;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        req_i;
  logic        pc_set_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  exc_cause_t  exc_cause_i;
  addr_t       branch_target_ex_i;
  addr_t       csr_mepc_i;
  addr_t       csr_depc_i;
  addr_t       csr_mtvec_i;
  addr_t       boot_addr_i;
  logic        csr_mtvec_init_o;
  logic        id_in_ready_i;
  logic        instr_valid_clear_i;
  logic        pmp_err_if_i;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  instr_t      instr_rdata_id_o;
  addr_t       pc_id_o;
  logic        instr_fetch_err_o;
  addr_t       pc_if_o;
  logic        if_busy_o;
  logic        instr_req_o;
  addr_t       instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  instr_t      instr_rdata_i;
  logic        instr_bus_err_i;

  // reference state
  string test_name      = "reset";
  addr_t exp_pc         = '0;
  logic  exp_known      = 1'b0;
  logic  pmp_prev       = 1'b0;
  addr_t pc_if_prev     = '0;
  int    new_count      = 0;
  int    outstanding    = 0;
  logic  hold_ready_low = 1'b0;

  // 8 ns period
  always #4 clk_i = ~clk_i;

  fetch_stage i_fetch_stage (.*);

  fetch_mem_model i_mem_model (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .instr_req_i     (instr_req_o),
    .instr_addr_i    (instr_addr_o),
    .instr_gnt_o     (instr_gnt_i),
    .instr_rvalid_o  (instr_rvalid_i),
    .instr_rdata_o   (instr_rdata_i),
    .instr_bus_err_o (instr_bus_err_i)
  );

  task automatic report_fail(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      report_fail($sformatf("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act));
    end
  endtask

  // next fetch address as the pc and handler mux rules define it
  function automatic addr_t target_addr(input pc_sel_e pc_sel, input exc_pc_sel_e exc_sel,
                                        input exc_cause_t cause);
    addr_t      mtvec_base;
    logic [4:0] vec;
    addr_t      result;
    mtvec_base = {csr_mtvec_i[31:8], 8'h00};
    vec        = cause.irq_int ? 5'd31 : cause.lower_cause;
    case (pc_sel)
      PC_BOOT: result = {boot_addr_i[31:8], 8'h80};
      PC_JUMP: result = branch_target_ex_i;
      PC_ERET: result = csr_mepc_i;
      PC_DRET: result = csr_depc_i;
      default: begin
        case (exc_sel)
          EXC_PC_IRQ:     result = mtvec_base + {25'd0, vec, 2'b00};
          EXC_PC_DBD:     result = 32'h1A11_0800;
          EXC_PC_DBG_EXC: result = 32'h1A11_0808;
          default:        result = mtvec_base;
        endcase
      end
    endcase
    return result;
  endfunction

  ////////////////////
  // reference monitor
  ////////////////////

  // sampled mid cycle, all inputs and outputs are settled here
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (instr_new_id_o) begin
        if (!exp_known) begin
          report_fail("new instruction reached ID before the first pc set");
        end
        check_value("pc_id_o", exp_pc, pc_id_o);
        // head of the queue in the transfer cycle, one cycle back
        check_value("pc_if_o", exp_pc, pc_if_prev);
        check_value("instr_rdata_id_o", exp_pc ^ DataMask, instr_rdata_id_o);
        // pmp value from the transfer cycle, one cycle back
        check_value("instr_fetch_err_o", exp_pc[12] | pmp_prev, instr_fetch_err_o);
        exp_pc    = exp_pc + 32'd4;
        new_count = new_count + 1;
      end
      // words loaded before the set were checked above against the old path
      if (pc_set_i) begin
        exp_pc    = target_addr(pc_mux_i, exc_pc_mux_i, exc_cause_i);
        exp_known = 1'b1;
      end
      if (instr_req_o && outstanding != 0) begin
        report_fail("second bus request issued while a response was still pending");
      end
      if (instr_rvalid_i) begin
        outstanding = outstanding - 1;
      end
      if (instr_req_o && instr_gnt_i) begin
        outstanding = outstanding + 1;
      end
      pmp_prev   = pmp_err_if_i;
      pc_if_prev = pc_if_o;
    end
  end

  ////////////////////
  // assertions
  ////////////////////

  a_mtvec_init: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_mtvec_init_o == (pc_set_i && (pc_mux_i == PC_BOOT)))
    else report_fail($sformatf("[FAIL] %s csr_mtvec_init_o expected %0b actual %0b",
                               test_name, pc_set_i && (pc_mux_i == PC_BOOT), csr_mtvec_init_o));

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else report_fail("bus request dropped or its address changed before the grant");

  a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_id_o && !instr_valid_clear_i |=> instr_valid_id_o)
    else report_fail($sformatf("[FAIL] %s instr_valid_id_o expected 1 actual 0", test_name));

  a_valid_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_clear_i |=> !instr_valid_id_o || instr_new_id_o)
    else report_fail("instr_valid_id_o stayed high after a clear without a new instruction");

  // a word offered in the set cycle must be squashed
  a_set_squash: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> !instr_new_id_o)
    else report_fail("an instruction was taken into ID during a pc set cycle");

  ////////////////////
  // stimulus
  ////////////////////

  // decode side, random stalls, pmp faults and clears
  initial begin
    logic stall;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;
    pmp_err_if_i        = 1'b0;
    forever begin
      @(posedge clk_i);
      stall = hold_ready_low;
      #1;
      id_in_ready_i       = !stall && ($urandom_range(1, 0) == 1);
      pmp_err_if_i        = ($urandom_range(7, 0) == 0);
      instr_valid_clear_i = ($urandom_range(3, 0) == 0);
    end
  end

  task automatic wait_new(input int n);
    int goal;
    int cycles;
    goal   = new_count + n;
    cycles = 0;
    while (new_count < goal) begin
      if (cycles == NewTimeout) begin
        report_fail($sformatf("timeout in %s, %0d new instructions missing after %0d cycles",
                              test_name, goal - new_count, cycles));
      end
      @(posedge clk_i);
      #1;
      cycles = cycles + 1;
    end
  endtask

  // want_idle selects bus idle, otherwise granted and waiting for rvalid
  task automatic wait_bus(input logic want_idle);
    int cycles;
    cycles = 0;
    while (want_idle ? if_busy_o : !(if_busy_o && !instr_req_o)) begin
      if (cycles == BusTimeout) begin
        report_fail($sformatf("timeout in %s waiting for the bus state", test_name));
      end
      @(posedge clk_i);
      #1;
      cycles = cycles + 1;
    end
  endtask

  task automatic pulse_pc_set(input pc_sel_e pc_sel, input exc_pc_sel_e exc_sel,
                              input exc_cause_t cause);
    pc_set_i     = 1'b1;
    pc_mux_i     = pc_sel;
    exc_pc_mux_i = exc_sel;
    exc_cause_i  = cause;
    @(posedge clk_i);
    #1;
    pc_set_i = 1'b0;
  endtask

  task automatic run_target(input string name, input pc_sel_e pc_sel,
                            input exc_pc_sel_e exc_sel, input exc_cause_t cause, input int n);
    test_name = name;
    pulse_pc_set(pc_sel, exc_sel, cause);
    wait_new(n);
  endtask

  initial begin
    void'($urandom(Seed));
    rst_ni             = 1'b0;
    req_i              = 1'b0;
    pc_set_i           = 1'b0;
    pc_mux_i           = PC_BOOT;
    exc_pc_mux_i       = EXC_PC_EXC;
    exc_cause_i        = '0;
    branch_target_ex_i = 32'h0000_0FF0;
    csr_mepc_i         = 32'h0000_5A40;
    csr_depc_i         = 32'h0000_1FF8;
    csr_mtvec_i        = 32'h0000_1F41;
    boot_addr_i        = 32'h0000_2345;
    // outputs stay low through reset
    repeat (8) begin
      @(posedge clk_i);
      #1;
      check_value("instr_req_o", '0, instr_req_o);
      check_value("instr_valid_id_o", '0, instr_valid_id_o);
      check_value("instr_new_id_o", '0, instr_new_id_o);
      check_value("if_busy_o", '0, if_busy_o);
    end
    rst_ni = 1'b1;
    req_i  = 1'b1;
    @(posedge clk_i);
    #1;
    run_target("boot", PC_BOOT, EXC_PC_EXC, '0, 8);
    test_name = "stream";
    wait_new(40);
    // jump target crosses into a faulting block
    run_target("jump", PC_JUMP, EXC_PC_EXC, '0, 8);
    run_target("exc_base", PC_EXC, EXC_PC_EXC, '0, 4);
    run_target("irq_vector", PC_EXC, EXC_PC_IRQ,
               exc_cause_t'{irq_int: 1'b0, lower_cause: 5'd5}, 4);
    run_target("irq_nmi", PC_EXC, EXC_PC_IRQ,
               exc_cause_t'{irq_int: 1'b1, lower_cause: 5'd3}, 4);
    run_target("debug_halt", PC_EXC, EXC_PC_DBD, '0, 4);
    run_target("debug_exc", PC_EXC, EXC_PC_DBG_EXC, '0, 4);
    run_target("mret", PC_ERET, EXC_PC_EXC, '0, 4);
    run_target("dret", PC_DRET, EXC_PC_EXC, '0, 6);
    // decode stalls, the queue fills and the bus goes quiet
    test_name      = "backpressure";
    hold_ready_low = 1'b1;
    // ready driven in this cycle may still pop one word
    @(posedge clk_i);
    #1;
    wait_bus(1'b1);
    repeat (5) begin
      @(posedge clk_i);
      #1;
      check_value("instr_req_o", '0, instr_req_o);
    end
    hold_ready_low = 1'b0;
    wait_new(12);
    // redirect while a response is still on its way
    test_name = "squash";
    repeat (6) begin
      wait_bus(1'b0);
      branch_target_ex_i = 32'h0000_6000 + ($urandom_range(1023, 0) << 2);
      pulse_pc_set(PC_JUMP, EXC_PC_EXC, '0);
      wait_new(3);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== project.f ====
hw/fetch_pkg.sv
hw/fetch_target_sel.sv
hw/fetch_buffer.sv
hw/fetch_id_reg.sv
hw/fetch_stage.sv
verification/fetch_mem_model.sv
verification/fetch_stage_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - hw/fetch_pkg.sv
  - hw/fetch_target_sel.sv
  - hw/fetch_buffer.sv
  - hw/fetch_id_reg.sv
  - hw/fetch_stage.sv
  - target: test
    files:
      - verification/fetch_mem_model.sv
      - verification/fetch_stage_tb.sv
